// ==== common/clk_macros.svh ====
// Clock board shared constants
// Field widths, diagnostic function codes and the rate divider periods

`ifndef CLK_MACROS_SVH
`define CLK_MACROS_SVH

`define CLK_BURST_W       8     // Burst counter
`define CLK_NIBBLE_W      4     // EBUS load field
`define CLK_DIAG_W        6     // Readback field, EBUS bits 30-35
`define CLK_FUNC_W        3
`define CLK_RATE_DIV_W    3

// Diagnostic control functions 00x
`define CLK_FUNC_STOP     3'd0
`define CLK_FUNC_START    3'd1
`define CLK_FUNC_STEP     3'd2
`define CLK_FUNC_BURST    3'd5

// Diagnostic load functions 04x
`define CLK_LD_BURST_LSB  3'd2
`define CLK_LD_BURST_MSB  3'd3
`define CLK_LD_SELECT     3'd4

// Rate divider periods in CLK cycles, by rate select
`define CLK_RATE_PERIOD_0 1
`define CLK_RATE_PERIOD_1 2
`define CLK_RATE_PERIOD_2 4
`define CLK_RATE_PERIOD_3 8

`endif

// ==== common/clkPkg.sv ====
// Clock board types
// Vector typedefs, the command, load and status bundles passed between
// the diagnostic registers and the gate logic, and the gate FSM states
`default_nettype none

`include "clk_macros.svh"

package clkPkg;

  typedef logic [`CLK_BURST_W-1:0]    burstCount_t;
  typedef logic [`CLK_NIBBLE_W-1:0]   nibble_t;
  typedef logic [`CLK_FUNC_W-1:0]     diagFunc_t;
  typedef logic [`CLK_DIAG_W-1:0]     diagWord_t;
  typedef logic [1:0]                 rateSel_t;
  typedef logic [1:0]                 sourceSel_t;   // Stored and read back only
  typedef logic [`CLK_RATE_DIV_W-1:0] rateCount_t;

  // One-cycle commands from the 00x decoder
  typedef struct packed {
    logic start;
    logic stop;
    logic singleStep;
    logic burst;
  } clkCtlCmd_t;

  // Burst count nibble loads from functions 042/043
  typedef struct packed {
    logic    loadLsb;
    logic    loadMsb;
    nibble_t value;
  } clkBurstLoad_t;

  typedef struct packed {
    logic go;             // Free running
    logic burstActive;
    logic stepPending;    // Waiting for the rate tick of a single step
  } clkGateStatus_t;

  typedef enum logic [1:0] {
    gateIdle,
    gateRun,
    gateBurst,
    gateStep
  } gateState_t;

endpackage

`default_nettype wire

// ==== clkGate/clkRateGen.sv ====
// Clock rate divider
// Down-counting divider that marks the cycles allowed by the rate select.
// Periods of 1, 2, 4 or 8 cycles; a new select restarts the count at 0
`timescale 1ns/1ps
`default_nettype none

`include "clk_macros.svh"

module clkRateGen (
  input  logic             CLK,
  input  logic             FPGA_RESET,
  input  clkPkg::rateSel_t rateSel,
  output logic             rateTick
);
  import clkPkg::*;

  rateCount_t rateCount;
  rateCount_t periodLast;   // Reload value, period - 1
  rateSel_t   rateSelQ;     // Select seen last cycle
  logic       selChanged;

  always_comb begin
    case (rateSel)
      2'd0:    periodLast = rateCount_t'(`CLK_RATE_PERIOD_0 - 1);
      2'd1:    periodLast = rateCount_t'(`CLK_RATE_PERIOD_1 - 1);
      2'd2:    periodLast = rateCount_t'(`CLK_RATE_PERIOD_2 - 1);
      default: periodLast = rateCount_t'(`CLK_RATE_PERIOD_3 - 1);
    endcase
  end

  assign selChanged = (rateSel != rateSelQ);
  assign rateTick   = (rateCount == '0);

  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      rateCount <= '0;
      rateSelQ  <= '0;
    end else begin
      rateSelQ <= rateSel;
      if (selChanged) begin
        rateCount <= '0;              // Restart on a new select
      end else if (rateCount == '0) begin
        rateCount <= periodLast;
      end else begin
        rateCount <= rateCount - 1'b1;
      end
    end
  end

  // Once a select has settled the count stays inside its period
  rateCountInPeriod: assert property (
    @(posedge CLK) disable iff (FPGA_RESET)
    (rateSel == rateSelQ) |-> (rateCount <= periodLast)
  );

endmodule

`default_nettype wire

// ==== clkGate/clkGateCtl.sv ====
// Clock gate control
// Run, burst and single step FSM that turns rate ticks into the
// registered clock enable gatedEn, and steps the burst counter
`timescale 1ns/1ps
`default_nettype none

module clkGateCtl (
  input  logic                   CLK,
  input  logic                   FPGA_RESET,
  input  clkPkg::clkCtlCmd_t     cmd,
  input  logic                   rateTick,
  input  logic                   burstZero,
  output logic                   gatedEn,
  output logic                   burstStep,
  output clkPkg::clkGateStatus_t status
);
  import clkPkg::*;

  gateState_t state;
  gateState_t stateNext;
  logic       anyCmd;
  logic       pulseNext;    // gatedEn for the following cycle

  assign anyCmd = |cmd;

  always_comb begin
    stateNext = state;
    pulseNext = 1'b0;
    if (anyCmd) begin
      // A new command replaces whatever was running
      if (cmd.stop) begin
        stateNext = gateIdle;
      end else if (cmd.start) begin
        stateNext = gateRun;
      end else if (cmd.singleStep) begin
        stateNext = gateStep;
      end else begin
        stateNext = gateBurst;
      end
    end else begin
      case (state)
        gateRun: pulseNext = rateTick;
        gateStep: begin
          if (rateTick) begin
            pulseNext = 1'b1;
            stateNext = gateIdle;   // One pulse only
          end
        end
        gateBurst: begin
          if (burstZero) begin
            stateNext = gateIdle;
          end else begin
            pulseNext = rateTick;
          end
        end
        default: pulseNext = 1'b0;
      endcase
    end
  end

  // Counter steps on the same edge that raises gatedEn
  assign burstStep = pulseNext && (state == gateBurst);

  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      state   <= gateIdle;
      gatedEn <= 1'b0;
    end else begin
      state   <= stateNext;
      gatedEn <= pulseNext;
    end
  end

  assign status.go          = (state == gateRun);
  assign status.burstActive = (state == gateBurst);
  assign status.stepPending = (state == gateStep);

  // Only the last pulse of a step may show up once the FSM is idle again
  idlePulseFromPrevState: assert property (
    @(posedge CLK) disable iff (FPGA_RESET)
    (gatedEn && state == gateIdle) |-> ($past(state) != gateIdle)
  );

endmodule

`default_nettype wire

// ==== logic/clkBurstCounter.sv ====
// Burst counter
// Eight bit count loaded a nibble at a time by functions 042/043,
// counted down once per burst pulse. Zero ends the burst
`timescale 1ns/1ps
`default_nettype none

`include "clk_macros.svh"

module clkBurstCounter (
  input  logic                  CLK,
  input  logic                  FPGA_RESET,
  input  clkPkg::clkBurstLoad_t burstLoad,
  input  logic                  burstStep,
  output clkPkg::burstCount_t   burstCount,
  output logic                  burstZero
);
  import clkPkg::*;

  burstCount_t count;

  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      count <= '0;
    end else if (burstLoad.loadLsb || burstLoad.loadMsb) begin
      // Nibbles load independently
      if (burstLoad.loadLsb) begin
        count[`CLK_NIBBLE_W-1:0] <= burstLoad.value;
      end
      if (burstLoad.loadMsb) begin
        count[`CLK_BURST_W-1:`CLK_NIBBLE_W] <= burstLoad.value;
      end
    end else if (burstStep) begin
      count <= count - 1'b1;
    end
  end

  assign burstCount = count;
  assign burstZero  = (count == '0);

  // Gate FSM must stop stepping once the count has run out
  noStepAtZero: assert property (
    @(posedge CLK) disable iff (FPGA_RESET)
    burstStep |-> !burstZero
  );

endmodule

`default_nettype wire

// ==== logic/clkDiagRegs.sv ====
// Diagnostic registers
// Decodes the 00x control and 04x load strobes into commands, burst
// count loads and the rate/source selects, and muxes the diagnostic
// readback onto EBUS bits 30-35
`timescale 1ns/1ps
`default_nettype none

`include "clk_macros.svh"

module clkDiagRegs (
  input  logic                   CLK,
  input  logic                   FPGA_RESET,
  input  clkPkg::diagFunc_t      diagFunc,
  input  logic                   diagCtlStrobe,
  input  logic                   diagLoadStrobe,
  input  logic                   diagRead,
  input  clkPkg::nibble_t        ebusData,
  input  clkPkg::burstCount_t    burstCount,
  input  clkPkg::clkGateStatus_t status,
  output clkPkg::clkCtlCmd_t     cmd,
  output clkPkg::clkBurstLoad_t  burstLoad,
  output clkPkg::rateSel_t       rateSel,
  output logic                   ebusDriving,
  output clkPkg::diagWord_t      ebusReadData
);
  import clkPkg::*;

  sourceSel_t sourceSel;

  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      cmd       <= '0;
      burstLoad <= '0;
      rateSel   <= '0;
      sourceSel <= '0;
    end else begin
      cmd               <= '0;          // Commands last one cycle
      burstLoad.loadLsb <= 1'b0;
      burstLoad.loadMsb <= 1'b0;
      burstLoad.value   <= ebusData;

      if (diagCtlStrobe) begin
        case (diagFunc)
          `CLK_FUNC_STOP:  cmd.stop       <= 1'b1;
          `CLK_FUNC_START: cmd.start      <= 1'b1;
          `CLK_FUNC_STEP:  cmd.singleStep <= 1'b1;
          `CLK_FUNC_BURST: cmd.burst      <= 1'b1;
          default:         cmd            <= '0;   // Unused codes
        endcase
      end

      if (diagLoadStrobe) begin
        case (diagFunc)
          `CLK_LD_BURST_LSB: burstLoad.loadLsb <= 1'b1;
          `CLK_LD_BURST_MSB: burstLoad.loadMsb <= 1'b1;
          `CLK_LD_SELECT: begin
            sourceSel <= ebusData[1:0];
            rateSel   <= ebusData[3:2];
          end
          default: burstLoad.loadLsb <= 1'b0;
        endcase
      end
    end
  end

  assign ebusDriving = diagRead;

  // Readback, zero when not selected
  always_comb begin
    ebusReadData = '0;
    if (diagRead) begin
      case (diagFunc)
        3'd0:    ebusReadData = burstCount[7:2];
        3'd1:    ebusReadData = {burstCount[1:0], rateSel, sourceSel};
        3'd2: begin
          ebusReadData = {status.go, status.burstActive, status.stepPending, 3'b000};
        end
        default: ebusReadData = '0;
      endcase
    end
  end

  // Gate FSM relies on never seeing two commands at once
  cmdOneHot: assert property (
    @(posedge CLK) disable iff (FPGA_RESET)
    $onehot0(cmd)
  );

endmodule

`default_nettype wire

// ==== logic/clkBoard.sv ====
// Clock board top level
// Diagnostic clock control of the M8526 as a single clock design.
// gatedEn is a clock enable on CLK in place of the gated clock
`timescale 1ns/1ps
`default_nettype none

module clkBoard (
  input  logic              CLK,
  input  logic              FPGA_RESET,
  input  clkPkg::diagFunc_t diagFunc,
  input  logic              diagCtlStrobe,
  input  logic              diagLoadStrobe,
  input  logic              diagRead,
  input  clkPkg::nibble_t   ebusData,
  output logic              gatedEn,
  output logic              ebusDriving,
  output clkPkg::diagWord_t ebusReadData
);
  import clkPkg::*;

  clkCtlCmd_t     cmd;
  clkBurstLoad_t  burstLoad;
  rateSel_t       rateSel;
  logic           rateTick;
  logic           burstZero;
  logic           burstStep;
  burstCount_t    burstCount;
  clkGateStatus_t status;

  clkDiagRegs clkDiagRegs_i (
    .CLK            (CLK),
    .FPGA_RESET     (FPGA_RESET),
    .diagFunc       (diagFunc),
    .diagCtlStrobe  (diagCtlStrobe),
    .diagLoadStrobe (diagLoadStrobe),
    .diagRead       (diagRead),
    .ebusData       (ebusData),
    .burstCount     (burstCount),
    .status         (status),
    .cmd            (cmd),
    .burstLoad      (burstLoad),
    .rateSel        (rateSel),
    .ebusDriving    (ebusDriving),
    .ebusReadData   (ebusReadData)
  );

  clkRateGen clkRateGen_i (
    .CLK        (CLK),
    .FPGA_RESET (FPGA_RESET),
    .rateSel    (rateSel),
    .rateTick   (rateTick)
  );

  clkBurstCounter clkBurstCounter_i (
    .CLK        (CLK),
    .FPGA_RESET (FPGA_RESET),
    .burstLoad  (burstLoad),
    .burstStep  (burstStep),
    .burstCount (burstCount),
    .burstZero  (burstZero)
  );

  clkGateCtl clkGateCtl_i (
    .CLK        (CLK),
    .FPGA_RESET (FPGA_RESET),
    .cmd        (cmd),
    .rateTick   (rateTick),
    .burstZero  (burstZero),
    .gatedEn    (gatedEn),
    .burstStep  (burstStep),
    .status     (status)
  );

endmodule

`default_nettype wire

// ==== test/clkBoardTb.sv ====
// Clock board testbench
// Table of diagnostic operations applied in a loop, with gatedEn pulse
// counting over run windows, readback checks and a watchdog
`timescale 1ns/1ps
`default_nettype none

`include "clk_macros.svh"

module clkBoardTb;
  import clkPkg::*;

  typedef enum logic [1:0] {
    opCtl,
    opLoad,
    opRun,
    opRead
  } stepOp_t;

  typedef struct packed {
    stepOp_t   op;
    diagFunc_t func;
    nibble_t   data;
    int        cycles;      // Run window length
    int        expected;    // Pulse count or readback word
    int        spacing;     // Pulse spacing, 0 skips the check
  } stepEntry_t;

  logic      CLK;
  logic      FPGA_RESET;
  diagFunc_t diagFunc;
  logic      diagCtlStrobe;
  logic      diagLoadStrobe;
  logic      diagRead;
  nibble_t   ebusData;
  logic      gatedEn;
  logic      ebusDriving;
  diagWord_t ebusReadData;

  stepEntry_t stimTable[$];
  int         errorCount;
  int         watchdogCycles;

  clkBoard clkBoard_i (
    .CLK            (CLK),
    .FPGA_RESET     (FPGA_RESET),
    .diagFunc       (diagFunc),
    .diagCtlStrobe  (diagCtlStrobe),
    .diagLoadStrobe (diagLoadStrobe),
    .diagRead       (diagRead),
    .ebusData       (ebusData),
    .gatedEn        (gatedEn),
    .ebusDriving    (ebusDriving),
    .ebusReadData   (ebusReadData)
  );

  always #4 CLK = ~CLK;   // 8 ns period

  // Inputs change and outputs are sampled 1 ns after the rising edge
  task automatic nextCycle();
    @(posedge CLK);
    #1;
  endtask

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      errorCount++;
      $display("FAILED at %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
      $display("Errors found");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  function automatic void addStep(input stepOp_t op, input diagFunc_t func,
                                  input nibble_t data, input int cycles,
                                  input int expected, input int spacing);
    stepEntry_t entry;
    entry.op       = op;
    entry.func     = func;
    entry.data     = data;
    entry.cycles   = cycles;
    entry.expected = expected;
    entry.spacing  = spacing;
    stimTable.push_back(entry);
  endfunction

  function automatic void buildTable();
    // Readbacks straight out of reset
    addStep(opRead, 3'd0, 4'h0, 0, 0, 0);
    addStep(opRead, 3'd1, 4'h0, 0, 0, 0);
    addStep(opRead, 3'd2, 4'h0, 0, 0, 0);
    // Count 0x35, rate 2, source 1
    addStep(opLoad, `CLK_LD_BURST_MSB, 4'h3, 0, 0, 0);
    addStep(opLoad, `CLK_LD_BURST_LSB, 4'h5, 0, 0, 0);
    addStep(opLoad, `CLK_LD_SELECT, 4'b1001, 0, 0, 0);
    addStep(opRead, 3'd0, 4'h0, 0, 8'h35 >> 2, 0);
    addStep(opRead, 3'd1, 4'h0, 0, {2'b01, 2'b10, 2'b01}, 0);
    // Burst of 5 at rate 0, one pulse per cycle
    addStep(opLoad, `CLK_LD_SELECT, 4'b0000, 0, 0, 0);
    addStep(opLoad, `CLK_LD_BURST_LSB, 4'h5, 0, 0, 0);
    addStep(opLoad, `CLK_LD_BURST_MSB, 4'h0, 0, 0, 0);
    addStep(opCtl, `CLK_FUNC_BURST, 4'h0, 0, 0, 0);
    addStep(opRun, 3'd0, 4'h0, 20, 5, `CLK_RATE_PERIOD_0);
    addStep(opRead, 3'd0, 4'h0, 0, 0, 0);
    addStep(opRead, 3'd1, 4'h0, 0, 0, 0);
    addStep(opRead, 3'd2, 4'h0, 0, 0, 0);
    // Single step at rate 2
    addStep(opLoad, `CLK_LD_SELECT, 4'b1000, 0, 0, 0);
    addStep(opCtl, `CLK_FUNC_STEP, 4'h0, 0, 0, 0);
    addStep(opRun, 3'd0, 4'h0, 20, 1, 0);
    // Divider phase is fixed by the select load above, so 10 pulses fit in 40 cycles
    addStep(opCtl, `CLK_FUNC_START, 4'h0, 0, 0, 0);
    addStep(opRun, 3'd0, 4'h0, 40, 10, `CLK_RATE_PERIOD_2);
    addStep(opRead, 3'd2, 4'h0, 0, 6'b100000, 0);
    addStep(opCtl, `CLK_FUNC_STOP, 4'h0, 0, 0, 0);
    addStep(opRun, 3'd0, 4'h0, 20, 0, 0);
    addStep(opRead, 3'd2, 4'h0, 0, 0, 0);
    // Unused code 3, idle and then running
    addStep(opCtl, 3'd3, 4'h0, 0, 0, 0);
    addStep(opRead, 3'd2, 4'h0, 0, 0, 0);
    addStep(opCtl, `CLK_FUNC_START, 4'h0, 0, 0, 0);
    addStep(opCtl, 3'd3, 4'h0, 0, 0, 0);
    addStep(opRead, 3'd2, 4'h0, 0, 6'b100000, 0);
    addStep(opCtl, `CLK_FUNC_STOP, 4'h0, 0, 0, 0);
    addStep(opRead, 3'd2, 4'h0, 0, 0, 0);
  endfunction

  // One-cycle 00x strobe
  task automatic issueCommand(input diagFunc_t func);
    nextCycle();
    diagFunc      = func;
    diagCtlStrobe = 1'b1;
    nextCycle();
    diagCtlStrobe = 1'b0;
  endtask

  task automatic loadField(input diagFunc_t func, input nibble_t data);
    nextCycle();
    diagFunc       = func;
    ebusData       = data;
    diagLoadStrobe = 1'b1;
    nextCycle();
    diagLoadStrobe = 1'b0;
  endtask

  task automatic countPulses(input int cycles, input int expected, input int spacing);
    int pulses;
    int lastPulse;
    pulses    = 0;
    lastPulse = -1;
    for (int i = 0; i < cycles; i++) begin
      nextCycle();
      if (gatedEn) begin
        if (spacing > 0 && lastPulse >= 0) begin
          checkValue("gatedEn pulse spacing", i - lastPulse, spacing);
        end
        pulses++;
        lastPulse = i;
      end
    end
    checkValue("gatedEn pulse count", pulses, expected);
  endtask

  task automatic readDiag(input diagFunc_t func, input int expected);
    nextCycle();
    diagFunc = func;
    diagRead = 1'b1;
    #1;
    checkValue("ebusDriving", ebusDriving, 1);
    checkValue("ebusReadData", ebusReadData, expected);
    diagRead = 1'b0;
    #1;
    checkValue("ebusDriving", ebusDriving, 0);
    checkValue("ebusReadData", ebusReadData, 0);   // Bus released
  endtask

  initial begin
    CLK            = 1'b0;
    FPGA_RESET     = 1'b1;
    diagFunc       = '0;
    diagCtlStrobe  = 1'b0;
    diagLoadStrobe = 1'b0;
    diagRead       = 1'b0;
    ebusData       = '0;
    errorCount     = 0;
    buildTable();

    repeat (2) @(posedge CLK);
    #1;
    FPGA_RESET = 1'b0;
    checkValue("gatedEn", gatedEn, 0);
    checkValue("ebusDriving", ebusDriving, 0);

    foreach (stimTable[i]) begin
      case (stimTable[i].op)
        opCtl:   issueCommand(stimTable[i].func);
        opLoad:  loadField(stimTable[i].func, stimTable[i].data);
        opRun:   countPulses(stimTable[i].cycles, stimTable[i].expected, stimTable[i].spacing);
        default: readDiag(stimTable[i].func, stimTable[i].expected);
      endcase
    end

    if (errorCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Watchdog sized from the table once it is built
  initial begin
    #1;
    watchdogCycles = stimTable.size() * 20 + 100;
    repeat (watchdogCycles) @(posedge CLK);
    $display("Watchdog expired after %0d cycles before the table finished", watchdogCycles);
    $display("Errors found");
    $fatal(1, "Watchdog timeout");
  end

endmodule

`default_nettype wire

// ==== clkBoard.f ====
+incdir+common
common/clkPkg.sv
clkGate/clkRateGen.sv
clkGate/clkGateCtl.sv
logic/clkBurstCounter.sv
logic/clkDiagRegs.sv
logic/clkBoard.sv
test/clkBoardTb.sv
